/* verilog/mem_consts.svh */
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// Byte address width of a request.
`define MEM_ADDR_W 32

// Width of one bus word.
`define MEM_DATA_W 32

// Width of the request tag.
`define MEM_TAG_W 4

// Data RAM depth in words.
`define MEM_RAM_WORDS 256

// Cycles from a bus request to bus ready.
`define MEM_RAM_LATENCY 2

`endif

/* verilog/mem_pkg.sv */
`include "mem_consts.svh"

package mem_pkg;

	// Access width of a load or store.
	typedef enum logic [1:0] {
		MEM_BYTE = 2'd0,
		MEM_HALF = 2'd1,
		MEM_WORD = 2'd2
	} mem_width_e;

	// Request as it arrives from the pipeline.
	typedef struct packed {
		logic [`MEM_TAG_W-1:0]  tag;
		logic [4:0]             inst_rd;
		logic                   is_store;
		mem_width_e             width;
		logic                   is_signed;
		logic [`MEM_ADDR_W-1:0] address;
		logic [`MEM_DATA_W-1:0] wdata;
	} mem_req_t;

	// Decoded operation, store data already placed in its lane.
	typedef struct packed {
		logic [`MEM_TAG_W-1:0]  tag;
		logic [4:0]             inst_rd;
		logic                   is_store;
		mem_width_e             width;
		logic                   is_signed;
		logic [`MEM_ADDR_W-3:0] word_addr;
		logic [1:0]             lane;
		logic [`MEM_DATA_W-1:0] store_word;
		logic [`MEM_DATA_W-1:0] merge_mask;
		logic                   misaligned;
	} mem_op_t;

	// Word bus request, rw set for a write.
	typedef struct packed {
		logic                   rw;
		logic [`MEM_ADDR_W-1:0] address;
		logic [`MEM_DATA_W-1:0] wdata;
	} mem_bus_req_t;

	// Result handed to writeback.
	typedef struct packed {
		logic [`MEM_TAG_W-1:0]  tag;
		logic [4:0]             inst_rd;
		logic [`MEM_DATA_W-1:0] value;
		logic                   wb_en;
		logic                   fault;
	} mem_wb_t;

endpackage

/* verilog/stage_reg.sv */
module stage_reg #(
	parameter type payload_t = logic
) (
	input  logic     i_clock,
	input  logic     i_rst_n,
	input  logic     i_valid,
	output logic     o_ready,
	input  payload_t i_data,
	output logic     o_valid,
	input  logic     i_ready,
	output payload_t o_data
);

	logic     valid_q;
	logic     ready_en_q;
	payload_t data_q;

	// Stays closed for the first cycle after reset.
	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			ready_en_q <= 1'b0;
		end else begin
			ready_en_q <= 1'b1;
		end
	end

	// Take new data when empty or when the entry leaves on this edge.
	assign o_ready = ready_en_q && (!valid_q || i_ready);

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			valid_q <= 1'b0;
		end else if (o_ready) begin
			valid_q <= i_valid;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_valid && o_ready) begin
			data_q <= i_data;
		end
	end

	assign o_valid = valid_q;
	assign o_data  = data_q;

	a_hold_stable: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		o_valid && !i_ready |=> o_valid && $stable(o_data));

endmodule

/* verilog/mem_access_decode.sv */
`include "mem_consts.svh"

module mem_access_decode
	import mem_pkg::*;
(
	input  mem_req_t i_req,
	output mem_op_t  o_op
);

	logic [1:0]             lane;
	logic [4:0]             shift;
	logic                   misaligned;
	logic [`MEM_DATA_W-1:0] data_low;
	logic [`MEM_DATA_W-1:0] mask_low;

	assign lane  = i_req.address[1:0];
	assign shift = {lane, 3'b000};

	// Halves need an even address, words a multiple of four.
	always_comb begin
		case (i_req.width)
			MEM_HALF: misaligned = lane[0];
			MEM_WORD: misaligned = (lane != 2'b00);
			default:  misaligned = 1'b0;
		endcase
	end

	// Low part of the store data and the bits it covers.
	always_comb begin
		case (i_req.width)
			MEM_BYTE: begin
				data_low = {24'h0, i_req.wdata[7:0]};
				mask_low = 32'h0000_00ff;
			end
			MEM_HALF: begin
				data_low = {16'h0, i_req.wdata[15:0]};
				mask_low = 32'h0000_ffff;
			end
			default: begin
				data_low = i_req.wdata;
				mask_low = 32'hffff_ffff;
			end
		endcase
	end

	always_comb begin
		o_op.tag        = i_req.tag;
		o_op.inst_rd    = i_req.inst_rd;
		o_op.is_store   = i_req.is_store;
		o_op.width      = i_req.width;
		o_op.is_signed  = i_req.is_signed;
		o_op.word_addr  = i_req.address[`MEM_ADDR_W-1:2];
		o_op.lane       = lane;
		o_op.misaligned = misaligned;
		// Loads carry no store data.
		o_op.store_word = i_req.is_store ? (data_low << shift) : '0;
		o_op.merge_mask = i_req.is_store ? (mask_low << shift) : '0;
	end

endmodule

/* verilog/mem_access_engine.sv */
`include "mem_consts.svh"

module mem_access_engine
	import mem_pkg::*;
(
	input  logic                   i_clock,
	input  logic                   i_rst_n,
	input  logic                   i_op_valid,
	output logic                   o_op_ready,
	input  mem_op_t                i_op,
	output logic                   o_bus_request,
	output mem_bus_req_t           o_bus,
	input  logic                   i_bus_ready,
	input  logic [`MEM_DATA_W-1:0] i_bus_rdata,
	output logic                   o_done_valid,
	input  logic                   i_done_ready,
	output mem_op_t                o_done_op,
	output logic [`MEM_DATA_W-1:0] o_done_rdata
);

	typedef enum logic [1:0] {
		ST_IDLE  = 2'd0,
		ST_READ  = 2'd1,
		ST_WRITE = 2'd2,
		ST_DONE  = 2'd3
	} state_e;

	state_e                 state;
	mem_op_t                op_q;
	logic [`MEM_DATA_W-1:0] rdata_q;
	logic                   op_take;

	assign o_op_ready = (state == ST_IDLE);
	assign op_take    = i_op_valid && o_op_ready;

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (i_op_valid) begin
						if (i_op.misaligned) begin
							state <= ST_DONE;
						end else if (i_op.is_store && i_op.width == MEM_WORD) begin
							state <= ST_WRITE;
						end else begin
							state <= ST_READ;
						end
					end
				end
				ST_READ: begin
					// A narrow store goes on to write the merged word.
					if (i_bus_ready) begin
						state <= op_q.is_store ? ST_WRITE : ST_DONE;
					end
				end
				ST_WRITE: begin
					if (i_bus_ready) begin
						state <= ST_DONE;
					end
				end
				default: begin
					if (i_done_ready) begin
						state <= ST_IDLE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (op_take) begin
			op_q <= i_op;
		end
		if (state == ST_READ && i_bus_ready) begin
			rdata_q <= i_bus_rdata;
		end
	end

	// Word stores have a full mask, so the old word drops out of the merge.
	always_comb begin
		o_bus.rw      = (state == ST_WRITE);
		o_bus.address = {op_q.word_addr, 2'b00};
		o_bus.wdata   = (rdata_q & ~op_q.merge_mask) | (op_q.store_word & op_q.merge_mask);
	end

	assign o_bus_request = (state == ST_READ) || (state == ST_WRITE);

	assign o_done_valid = (state == ST_DONE);
	assign o_done_op    = op_q;
	assign o_done_rdata = rdata_q;

	a_misaligned_no_bus: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		o_bus_request |-> !op_q.misaligned);

	a_bus_stable: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		o_bus_request && !i_bus_ready |=> o_bus_request && $stable(o_bus));

endmodule

/* verilog/load_align.sv */
`include "mem_consts.svh"

module load_align
	import mem_pkg::*;
(
	input  logic                   i_done_valid,
	output logic                   o_done_ready,
	input  mem_op_t                i_done_op,
	input  logic [`MEM_DATA_W-1:0] i_done_rdata,
	output logic                   o_wb_valid,
	input  logic                   i_wb_ready,
	output mem_wb_t                o_wb
);

	logic [`MEM_DATA_W-1:0] shifted;
	logic [`MEM_DATA_W-1:0] load_value;
	logic                   is_load;

	// Bring the addressed lane down to bit zero.
	assign shifted = i_done_rdata >> {i_done_op.lane, 3'b000};

	always_comb begin
		case (i_done_op.width)
			MEM_BYTE: begin
				load_value = {{24{i_done_op.is_signed & shifted[7]}}, shifted[7:0]};
			end
			MEM_HALF: begin
				load_value = {{16{i_done_op.is_signed & shifted[15]}}, shifted[15:0]};
			end
			default: begin
				load_value = shifted;
			end
		endcase
	end

	assign is_load = !i_done_op.is_store && !i_done_op.misaligned;

	always_comb begin
		o_wb.tag     = i_done_op.tag;
		o_wb.inst_rd = i_done_op.inst_rd;
		o_wb.value   = is_load ? load_value : '0;
		o_wb.wb_en   = is_load;
		o_wb.fault   = i_done_op.misaligned;
	end

	assign o_wb_valid   = i_done_valid;
	assign o_done_ready = i_wb_ready;

endmodule

/* verilog/data_ram.sv */
`include "mem_consts.svh"

module data_ram
	import mem_pkg::*;
(
	input  logic                   i_clock,
	input  logic                   i_rst_n,
	input  logic                   i_bus_request,
	input  mem_bus_req_t           i_bus,
	output logic                   o_bus_ready,
	output logic [`MEM_DATA_W-1:0] o_bus_rdata
);

	localparam int IDX_W = $clog2(`MEM_RAM_WORDS);
	localparam int CNT_W = $clog2(`MEM_RAM_LATENCY + 1);

	logic [`MEM_DATA_W-1:0] mem [0:`MEM_RAM_WORDS-1];
	logic [CNT_W-1:0]       wait_cnt;
	logic [IDX_W-1:0]       idx;

	// Word address, wrapped to the depth.
	assign idx = i_bus.address[2 +: IDX_W];

	assign o_bus_ready = i_bus_request && (wait_cnt == CNT_W'(`MEM_RAM_LATENCY));
	assign o_bus_rdata = mem[idx];

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			wait_cnt <= '0;
			for (int i = 0; i < `MEM_RAM_WORDS; i++) begin
				mem[i] <= '0;
			end
		end else begin
			// Restart the count once a transfer completes.
			if (!i_bus_request || o_bus_ready) begin
				wait_cnt <= '0;
			end else begin
				wait_cnt <= wait_cnt + 1'b1;
			end
			if (o_bus_ready && i_bus.rw) begin
				mem[idx] <= i_bus.wdata;
			end
		end
	end

endmodule

/* verilog/mem_stage_top.sv */
`include "mem_consts.svh"

module mem_stage_top
	import mem_pkg::*;
(
	input  logic     i_clock,
	input  logic     i_rst_n,
	input  logic     i_req_valid,
	output logic     o_req_ready,
	input  mem_req_t i_req,
	output logic     o_wb_valid,
	input  logic     i_wb_ready,
	output mem_wb_t  o_wb
);

	mem_op_t                dec_op;
	mem_op_t                op_data;
	logic                   op_valid;
	logic                   op_ready;
	logic                   bus_request;
	mem_bus_req_t           bus;
	logic                   bus_ready;
	logic [`MEM_DATA_W-1:0] bus_rdata;
	logic                   done_valid;
	logic                   done_ready;
	mem_op_t                done_op;
	logic [`MEM_DATA_W-1:0] done_rdata;
	logic                   wb_valid;
	logic                   wb_ready;
	mem_wb_t                wb_data;

	mem_access_decode decode0 (
		.i_req (i_req),
		.o_op  (dec_op)
	);

	stage_reg #(.payload_t(mem_op_t)) op_reg (
		.i_clock (i_clock),
		.i_rst_n (i_rst_n),
		.i_valid (i_req_valid),
		.o_ready (o_req_ready),
		.i_data  (dec_op),
		.o_valid (op_valid),
		.i_ready (op_ready),
		.o_data  (op_data)
	);

	mem_access_engine engine0 (
		.i_clock       (i_clock),
		.i_rst_n       (i_rst_n),
		.i_op_valid    (op_valid),
		.o_op_ready    (op_ready),
		.i_op          (op_data),
		.o_bus_request (bus_request),
		.o_bus         (bus),
		.i_bus_ready   (bus_ready),
		.i_bus_rdata   (bus_rdata),
		.o_done_valid  (done_valid),
		.i_done_ready  (done_ready),
		.o_done_op     (done_op),
		.o_done_rdata  (done_rdata)
	);

	load_align align0 (
		.i_done_valid (done_valid),
		.o_done_ready (done_ready),
		.i_done_op    (done_op),
		.i_done_rdata (done_rdata),
		.o_wb_valid   (wb_valid),
		.i_wb_ready   (wb_ready),
		.o_wb         (wb_data)
	);

	stage_reg #(.payload_t(mem_wb_t)) wb_reg (
		.i_clock (i_clock),
		.i_rst_n (i_rst_n),
		.i_valid (wb_valid),
		.o_ready (wb_ready),
		.i_data  (wb_data),
		.o_valid (o_wb_valid),
		.i_ready (i_wb_ready),
		.o_data  (o_wb)
	);

	data_ram ram0 (
		.i_clock       (i_clock),
		.i_rst_n       (i_rst_n),
		.i_bus_request (bus_request),
		.i_bus         (bus),
		.o_bus_ready   (bus_ready),
		.o_bus_rdata   (bus_rdata)
	);

endmodule

/* testbench/tb_mem_stage.sv */
`include "mem_consts.svh"

module tb_mem_stage
	import mem_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int MAX_CASES  = 64;
	localparam int WAIT_LIMIT = 200;

	// One line of the case file.
	typedef struct packed {
		mem_req_t               req;
		logic [`MEM_DATA_W-1:0] value;
		logic                   fault;
	} case_t;

	logic     clock;
	logic     rst_n;
	logic     req_valid;
	logic     req_ready;
	mem_req_t req;
	logic     wb_valid;
	logic     wb_ready;
	mem_wb_t  wb;

	case_t cases [0:MAX_CASES-1];
	int    num_cases;
	int    errors;
	int    failures;
	int    seed;

	mem_stage_top dut0 (
		.i_clock     (clock),
		.i_rst_n     (rst_n),
		.i_req_valid (req_valid),
		.o_req_ready (req_ready),
		.i_req       (req),
		.o_wb_valid  (wb_valid),
		.i_wb_ready  (wb_ready),
		.o_wb        (wb)
	);

	always #4 clock = ~clock;

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			errors++;
			$display("** Error: %s is 0x%h, expected 0x%h at %0t ns",
				name, actual, expected, $time);
		end
	endtask

	task automatic load_cases();
		int          fd;
		int          count;
		string       line;
		logic [31:0] field [0:8];
		case_t       c;
		num_cases = 0;
		fd = $fopen("testbench/mem_cases.txt", "r");
		if (fd == 0) begin
			$display("Could not open testbench/mem_cases.txt");
			failures++;
		end else begin
			while ($fgets(line, fd) != 0 && num_cases < MAX_CASES) begin
				count = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
					field[0], field[1], field[2], field[3], field[4],
					field[5], field[6], field[7], field[8]);
				// Comment lines do not scan
				if (count == 9) begin
					c.req.is_store  = field[0][0];
					c.req.width     = mem_width_e'(field[1][1:0]);
					c.req.is_signed = field[2][0];
					c.req.address   = field[3];
					c.req.wdata     = field[4];
					c.req.tag       = field[5][`MEM_TAG_W-1:0];
					c.req.inst_rd   = field[6][4:0];
					c.value         = field[7];
					c.fault         = field[8][0];
					cases[num_cases] = c;
					num_cases++;
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic send_requests();
		int   waited;
		logic accepted;
		@(posedge clock);
		for (int i = 0; i < num_cases; i++) begin
			req_valid <= 1'b1;
			req       <= cases[i].req;
			accepted = 1'b0;
			waited   = 0;
			// Ready is sampled mid-cycle, the transfer is on the next edge.
			while (!accepted && waited < WAIT_LIMIT) begin
				@(negedge clock);
				accepted = req_ready;
				waited++;
				@(posedge clock);
			end
			if (!accepted) begin
				$display("Timeout: request of case %0d was never accepted", i);
				failures++;
				break;
			end
		end
		req_valid <= 1'b0;
	endtask

	task automatic check_results();
		int    waited;
		logic  got;
		case_t c;
		for (int i = 0; i < num_cases; i++) begin
			c      = cases[i];
			got    = 1'b0;
			waited = 0;
			while (!got && waited < WAIT_LIMIT) begin
				@(posedge clock);
				// Ready about three cycles in four.
				wb_ready <= (($random(seed) & 3) != 0);
				@(negedge clock);
				got = wb_valid && wb_ready;
				waited++;
			end
			if (!got) begin
				$display("Timeout: no result for case %0d with tag 0x%h", i, c.req.tag);
				failures++;
				break;
			end
			check_value("o_wb.tag", 32'(wb.tag), 32'(c.req.tag));
			check_value("o_wb.inst_rd", 32'(wb.inst_rd), 32'(c.req.inst_rd));
			check_value("o_wb.value", wb.value, c.value);
			check_value("o_wb.wb_en", 32'(wb.wb_en), 32'(!c.req.is_store && !c.fault));
			check_value("o_wb.fault", 32'(wb.fault), 32'(c.fault));
		end
		// No result may follow the last one.
		@(posedge clock);
		wb_ready <= 1'b1;
		repeat (20) begin
			@(negedge clock);
			check_value("o_wb_valid", 32'(wb_valid), 32'd0);
		end
	endtask

	task automatic finish_run();
		$display("Run finished with %0d errors and %0d other failures", errors, failures);
		if (errors == 0 && failures == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	endtask

	initial begin
		clock     = 1'b0;
		rst_n     = 1'b0;
		req_valid = 1'b0;
		req       = '0;
		wb_ready  = 1'b0;
		errors    = 0;
		failures  = 0;
		seed      = 39152;
		load_cases();
		if (num_cases == 0) begin
			$display("No cases were read from the case file");
			failures++;
		end
		repeat (7) begin
			@(posedge clock);
			@(negedge clock);
			check_value("o_wb_valid", 32'(wb_valid), 32'd0);
			check_value("o_req_ready", 32'(req_ready), 32'd0);
		end
		// The eighth reset edge.
		@(posedge clock);
		rst_n <= 1'b1;
		@(negedge clock);
		check_value("o_wb_valid", 32'(wb_valid), 32'd0);
		check_value("o_req_ready", 32'(req_ready), 32'd0);
		fork
			send_requests();
			check_results();
		join
		finish_run();
	end

endmodule

/* testbench/mem_cases.txt */
# store width(0 byte, 1 half, 2 word) signed address wdata tag rd value fault, all in hex
# value and fault are the expected result of the case
1 2 0 00000010 11223344 0 01 00000000 0
0 2 0 00000010 00000000 1 02 11223344 0
1 2 0 00000020 a1b2c3d4 2 03 00000000 0
1 0 0 00000021 000000ee 3 04 00000000 0
1 1 0 00000022 00005566 4 05 00000000 0
1 0 0 00000020 00000077 5 06 00000000 0
0 2 0 00000020 00000000 6 07 5566ee77 0
1 2 0 00000030 80ff7f01 7 08 00000000 0
0 0 1 00000030 00000000 8 09 00000001 0
0 0 1 00000031 00000000 9 0a 0000007f 0
0 0 1 00000032 00000000 a 0b ffffffff 0
0 0 1 00000033 00000000 b 0c ffffff80 0
0 0 0 00000032 00000000 c 0d 000000ff 0
0 0 0 00000033 00000000 d 0e 00000080 0
0 1 1 00000030 00000000 e 0f 00007f01 0
0 1 1 00000032 00000000 f 10 ffff80ff 0
0 1 0 00000032 00000000 0 11 000080ff 0
0 0 0 00000031 00000000 1 12 0000007f 0
0 1 0 00000030 00000000 2 13 00007f01 0
1 1 0 00000011 0000dead 3 14 00000000 1
1 2 0 00000012 cafef00d 4 15 00000000 1
0 2 0 00000013 00000000 5 16 00000000 1
0 1 1 00000033 00000000 6 17 00000000 1
0 2 0 00000010 00000000 7 18 11223344 0
1 2 0 00000016 12345678 8 19 00000000 1
0 2 0 00000014 00000000 9 1a 00000000 0
1 1 0 00000040 1234abcd a 1b 00000000 0
1 1 0 00000042 ffff9876 b 1c 00000000 0
0 2 0 00000040 00000000 c 1d 9876abcd 0
0 1 1 00000042 00000000 d 1e ffff9876 0
1 0 0 00000043 0000005a e 1f 00000000 0
0 2 0 00000040 00000000 f 00 5a76abcd 0
0 0 1 00000041 00000000 0 01 ffffffab 0
1 2 0 000003fc 0badcafe 1 02 00000000 0
0 2 0 000003fc 00000000 2 03 0badcafe 0

/* vlog.f */
+incdir+verilog
verilog/mem_pkg.sv
verilog/stage_reg.sv
verilog/mem_access_decode.sv
verilog/mem_access_engine.sv
verilog/load_align.sv
verilog/data_ram.sv
verilog/mem_stage_top.sv
testbench/tb_mem_stage.sv

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_mem_stage -o sim_mem_stage
./obj_dir/sim_mem_stage | tee sim.log

if grep -qF "*** FAILED ***" sim.log; then
	echo "Simulation reported failure"
	exit 1
fi
echo "Simulation finished without failure"
